//--- design/dma_pkg.sv
// dma engine shared definitions
package dma_pkg;

	// --------------------
	// widths
	localparam int num_chan    = 4;
	localparam int data_w      = 8;
	localparam int chan_addr_w = 16;
	localparam int page_w      = 8;
	localparam int mem_addr_w  = 24;

	// --------------------
	// controller register offsets
	// offsets 0..7 hold the address/count pair of each channel
	typedef enum logic [3:0] {
		reg_status_cmd   = 4'h8, // status on read, command on write
		reg_request      = 4'h9,
		reg_mask_single  = 4'hA,
		reg_mode         = 4'hB,
		reg_clear_ff     = 4'hC,
		reg_master_clear = 4'hD,
		reg_clear_mask   = 4'hE,
		reg_mask_all     = 4'hF
	} reg_addr_e;

	// mode register bits 3:2
	typedef enum logic [1:0] {
		xfer_verify = 2'd0,
		xfer_write  = 2'd1, // device to memory
		xfer_read   = 2'd2  // memory to device
	} xfer_e;

	typedef enum logic [2:0] {
		st_idle    = 3'd0,
		st_start   = 3'd1,
		st_rd_wait = 3'd2,
		st_rd_data = 3'd3,
		st_update  = 3'd4,
		st_done    = 3'd5,
		st_wr_wait = 3'd6,
		st_verify  = 3'd7
	} chan_state_e;

	// page port offset per channel, channel 0 in the low nibble
	localparam logic [num_chan-1:0][3:0] page_offsets = {4'h2, 4'h1, 4'h3, 4'h7};

	// --------------------
	// bus structs
	typedef struct packed {
		logic [3:0]        address;
		logic              read;
		logic              write;
		logic [data_w-1:0] writedata;
		logic              dma_cs;  // controller ports
		logic              page_cs; // page ports
	} io_req_t;

	// channel side of the memory port, page not yet added
	typedef struct packed {
		logic [chan_addr_w-1:0] address;
		logic                   read;
		logic                   write;
		logic [data_w-1:0]      writedata;
	} chan_mem_t;

	typedef struct packed {
		logic [mem_addr_w-1:0] address;
		logic                  read;
		logic                  write;
		logic [data_w-1:0]     writedata;
	} mem_req_t;

	typedef struct packed {
		logic              waitrequest;
		logic              readdatavalid;
		logic [data_w-1:0] readdata;
	} mem_rsp_t;

endpackage

//--- design/dma_chan.sv
// dma channel engine
`timescale 1ns/1ps

module dma_chan #(
	parameter int chan_num = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       master_clear,
	input  dma_pkg::io_req_t           io,
	input  logic                       flip_flop,
	output logic [dma_pkg::data_w-1:0] readdata,
	input  logic                       grant,
	input  logic [dma_pkg::data_w-1:0] dev_writedata,
	output logic                       ack,
	output logic [dma_pkg::data_w-1:0] ack_data,
	output dma_pkg::chan_mem_t         chan_mem,
	input  dma_pkg::mem_rsp_t          mem_rsp,
	output logic                       busy,
	output logic                       tc,
	output logic                       auto_init
);

	logic                            io_wr;
	logic                            sel_addr;
	logic                            sel_cnt;
	logic                            sel_mode;
	logic [dma_pkg::chan_addr_w-1:0] base_addr;
	logic [dma_pkg::chan_addr_w-1:0] cur_addr;
	logic [dma_pkg::chan_addr_w-1:0] base_cnt;
	logic [dma_pkg::chan_addr_w-1:0] cur_cnt;
	logic                            dec;
	dma_pkg::xfer_e                  xfer;
	dma_pkg::chan_state_e            state;
	logic                            posted;   // request is live on the memory port
	logic                            accepted;
	logic                            update;
	logic [dma_pkg::data_w-1:0]      wdata;

	assign io_wr    = io.write & io.dma_cs;
	assign sel_addr = io.address == 4'(2 * chan_num);
	assign sel_cnt  = io.address == 4'(2 * chan_num + 1);
	assign sel_mode = io_wr && io.address == dma_pkg::reg_mode
		&& io.writedata[1:0] == 2'(chan_num);

	// current values, byte picked by the flip-flop
	always_comb begin
		readdata = '0;
		if (sel_addr)
			readdata = cur_addr[flip_flop * dma_pkg::data_w +: dma_pkg::data_w];
		else if (sel_cnt)
			readdata = cur_cnt[flip_flop * dma_pkg::data_w +: dma_pkg::data_w];
	end

	// --------------------
	// address and count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			base_addr <= '0;
			cur_addr  <= '0;
		end else if (io_wr && sel_addr) begin
			base_addr[flip_flop * dma_pkg::data_w +: dma_pkg::data_w] <= io.writedata;
			cur_addr[flip_flop * dma_pkg::data_w +: dma_pkg::data_w]  <= io.writedata;
		end else if (tc && auto_init) begin
			cur_addr <= base_addr; // reload wins over the step
		end else if (update) begin
			cur_addr <= dec ? cur_addr - 1'b1 : cur_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			base_cnt <= '0;
			cur_cnt  <= '0;
		end else if (io_wr && sel_cnt) begin
			base_cnt[flip_flop * dma_pkg::data_w +: dma_pkg::data_w] <= io.writedata;
			cur_cnt[flip_flop * dma_pkg::data_w +: dma_pkg::data_w]  <= io.writedata;
		end else if (tc && auto_init) begin
			cur_cnt <= base_cnt;
		end else if (update) begin
			cur_cnt <= cur_cnt - 1'b1;
		end
	end

	// mode bits: 5 dec, 4 auto-init, 3:2 transfer type
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec       <= 1'b0;
			auto_init <= 1'b0;
			xfer      <= dma_pkg::xfer_verify;
		end else if (sel_mode) begin
			dec       <= io.writedata[5];
			auto_init <= io.writedata[4];
			xfer      <= dma_pkg::xfer_e'(io.writedata[3:2]);
		end
	end

	// --------------------
	// transfer fsm
	assign update   = state == dma_pkg::st_update;
	assign accepted = posted & ~mem_rsp.waitrequest;
	assign busy     = state != dma_pkg::st_idle;
	assign tc       = update && cur_cnt == '0;
	assign ack      = update; // one pulse per byte

	always_ff @(posedge clk) begin
		if (!rst_n || master_clear) begin
			state  <= dma_pkg::st_idle;
			posted <= 1'b0;
		end else begin
			// arbiter output trails the channel by one cycle
			posted <= (state == dma_pkg::st_rd_wait || state == dma_pkg::st_wr_wait)
				&& !accepted;
			case (state)
				dma_pkg::st_idle: if (grant) state <= dma_pkg::st_start;
				dma_pkg::st_start: begin
					case (xfer)
						dma_pkg::xfer_read:  state <= dma_pkg::st_rd_wait;
						dma_pkg::xfer_write: state <= dma_pkg::st_wr_wait;
						default:             state <= dma_pkg::st_verify;
					endcase
				end
				dma_pkg::st_rd_wait: if (accepted) state <= dma_pkg::st_rd_data;
				dma_pkg::st_rd_data: if (mem_rsp.readdatavalid) state <= dma_pkg::st_update;
				dma_pkg::st_wr_wait: if (accepted) state <= dma_pkg::st_update;
				dma_pkg::st_verify:  state <= dma_pkg::st_update;
				dma_pkg::st_update:  state <= dma_pkg::st_done;
				default:             state <= dma_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == dma_pkg::st_start)
			wdata <= dev_writedata; // device byte taken at the start
		if (state == dma_pkg::st_rd_data && mem_rsp.readdatavalid)
			ack_data <= mem_rsp.readdata;
	end

	// request drops in the cycle it is accepted
	always_comb begin
		chan_mem.address   = cur_addr;
		chan_mem.read      = state == dma_pkg::st_rd_wait && !accepted;
		chan_mem.write     = state == dma_pkg::st_wr_wait && !accepted;
		chan_mem.writedata = wdata;
	end

endmodule

//--- design/dma_regs.sv
// dma controller common registers
`timescale 1ns/1ps

module dma_regs (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  dma_pkg::io_req_t                                 io,
	input  logic [dma_pkg::num_chan-1:0]                     dreq,
	input  logic [dma_pkg::num_chan-1:0]                     tc,
	input  logic [dma_pkg::num_chan-1:0]                     auto_init,
	input  logic [dma_pkg::num_chan-1:0][dma_pkg::data_w-1:0] chan_readdata,
	output logic [dma_pkg::data_w-1:0]                       readdata,
	output logic                                             flip_flop,
	output logic                                             master_clear,
	output logic [dma_pkg::num_chan-1:0]                     req,
	output logic                                             disabled
);

	logic                         io_rd;
	logic                         io_wr;
	logic                         read_last;
	logic                         read_valid;
	logic [dma_pkg::num_chan-1:0] chan_bit;   // channel picked by writedata[1:0]
	logic [dma_pkg::num_chan-1:0] pending;
	logic [dma_pkg::num_chan-1:0] soft_req;
	logic [dma_pkg::num_chan-1:0] mask;
	logic [dma_pkg::num_chan-1:0] terminated;
	logic [dma_pkg::data_w-1:0]   chan_rd;

	assign io_rd        = io.read & io.dma_cs;
	assign io_wr        = io.write & io.dma_cs;
	assign read_valid   = io_rd && !read_last; // held read counts once
	assign master_clear = io_wr && io.address == dma_pkg::reg_master_clear;
	assign req          = pending & ~mask;

	always_comb begin
		chan_bit = '0;
		chan_bit[io.writedata[1:0]] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			read_last <= 1'b0;
		else
			read_last <= io_rd;
	end

	// --------------------
	// flip-flop and command
	always_ff @(posedge clk) begin
		if (!rst_n || master_clear || (io_wr && io.address == dma_pkg::reg_clear_ff))
			flip_flop <= 1'b0;
		else if ((read_valid || io_wr) && !io.address[3])
			flip_flop <= ~flip_flop;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || master_clear)
			disabled <= 1'b0;
		else if (io_wr && io.address == dma_pkg::reg_status_cmd)
			disabled <= io.writedata[2];
	end

	// --------------------
	// request, mask, status
	always_ff @(posedge clk) begin
		if (!rst_n || master_clear) begin
			soft_req <= '0;
			pending  <= '0;
		end else begin
			pending <= dreq | soft_req;
			if (io_wr && io.address == dma_pkg::reg_request)
				soft_req <= io.writedata[2] ? soft_req | chan_bit : soft_req & ~chan_bit;
			else
				soft_req <= soft_req & ~tc; // software request ends at tc
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || master_clear)
			mask <= '1;
		else if (io_wr && io.address == dma_pkg::reg_clear_mask)
			mask <= '0;
		else if (io_wr && io.address == dma_pkg::reg_mask_all)
			mask <= io.writedata[dma_pkg::num_chan-1:0];
		else if (io_wr && io.address == dma_pkg::reg_mask_single)
			mask <= io.writedata[2] ? mask | chan_bit : mask & ~chan_bit;
		else
			mask <= mask | (tc & ~auto_init); // re-mask at end of block
	end

	always_ff @(posedge clk) begin
		if (!rst_n || master_clear)
			terminated <= '0;
		else if (read_valid && io.address == dma_pkg::reg_status_cmd)
			terminated <= tc; // keep a tc landing on the read
		else
			terminated <= terminated | tc;
	end

	// --------------------
	// readback
	always_comb begin
		chan_rd = '0;
		for (int i = 0; i < dma_pkg::num_chan; i++)
			chan_rd |= chan_readdata[i];
	end

	always_ff @(posedge clk) begin
		if (read_valid) begin
			if (!io.address[3])
				readdata <= chan_rd;
			else if (io.address == dma_pkg::reg_status_cmd)
				readdata <= {pending, terminated};
			else if (io.address == dma_pkg::reg_mask_all)
				readdata <= {{(dma_pkg::data_w - dma_pkg::num_chan){1'b0}}, mask};
			else
				readdata <= '0;
		end
	end

endmodule

//--- design/dma_page.sv
// dma page registers
`timescale 1ns/1ps

module dma_page (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  dma_pkg::io_req_t                                 io,
	output logic [dma_pkg::num_chan-1:0][dma_pkg::page_w-1:0] page,
	output logic [dma_pkg::data_w-1:0]                       readdata
);

	// address bits 23..16 per channel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			page <= '0;
		end else if (io.write && io.page_cs) begin
			for (int i = 0; i < dma_pkg::num_chan; i++) begin
				if (io.address == dma_pkg::page_offsets[i])
					page[i] <= io.writedata;
			end
		end
	end

	// unmapped offsets read as zero
	always_ff @(posedge clk) begin
		if (io.read && io.page_cs) begin
			readdata <= '0;
			for (int i = 0; i < dma_pkg::num_chan; i++) begin
				if (io.address == dma_pkg::page_offsets[i])
					readdata <= page[i];
			end
		end
	end

endmodule

//--- design/dma_arbiter.sv
// dma channel arbiter and memory port
`timescale 1ns/1ps

module dma_arbiter (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  logic [dma_pkg::num_chan-1:0]                     req,
	input  logic                                             disabled,
	input  logic [dma_pkg::num_chan-1:0]                     busy,
	input  logic [dma_pkg::num_chan-1:0][dma_pkg::page_w-1:0] page,
	input  dma_pkg::chan_mem_t [dma_pkg::num_chan-1:0]       chan_mem,
	output logic [dma_pkg::num_chan-1:0]                     grant,
	output dma_pkg::mem_req_t                                mem_req
);

	// --------------------
	// fixed priority, channel 0 first
	// only one byte in flight, so grant waits for all channels idle
	always_comb begin
		grant = '0;
		if (!(|busy) && !disabled) begin
			for (int i = dma_pkg::num_chan - 1; i >= 0; i--) begin
				if (req[i]) begin
					grant    = '0;
					grant[i] = 1'b1;
				end
			end
		end
	end

	// --------------------
	// registered memory port
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_req.read  <= 1'b0;
			mem_req.write <= 1'b0;
		end else begin
			mem_req.read  <= 1'b0; // idle port
			mem_req.write <= 1'b0;
			for (int i = 0; i < dma_pkg::num_chan; i++) begin
				if (busy[i]) begin
					mem_req.read  <= chan_mem[i].read;
					mem_req.write <= chan_mem[i].write;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < dma_pkg::num_chan; i++) begin
			if (busy[i]) begin
				mem_req.address   <= {page[i], chan_mem[i].address};
				mem_req.writedata <= chan_mem[i].writedata;
			end
		end
	end

endmodule

//--- design/dma_top.sv
// isa dma engine top
`timescale 1ns/1ps

module dma_top (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  dma_pkg::io_req_t                                 io,
	output logic [dma_pkg::data_w-1:0]                       io_readdata,
	output dma_pkg::mem_req_t                                mem_req,
	input  dma_pkg::mem_rsp_t                                mem_rsp,
	input  logic [dma_pkg::num_chan-1:0]                     dreq,
	output logic [dma_pkg::num_chan-1:0]                     dack,
	output logic [dma_pkg::num_chan-1:0]                     tc,
	input  logic [dma_pkg::num_chan-1:0][dma_pkg::data_w-1:0] dev_writedata,
	output logic [dma_pkg::num_chan-1:0][dma_pkg::data_w-1:0] dev_readdata
);

	logic [dma_pkg::num_chan-1:0]                      req;
	logic [dma_pkg::num_chan-1:0]                      grant;
	logic [dma_pkg::num_chan-1:0]                      busy;
	logic [dma_pkg::num_chan-1:0]                      chan_tc;
	logic [dma_pkg::num_chan-1:0]                      auto_init;
	logic [dma_pkg::num_chan-1:0][dma_pkg::data_w-1:0] chan_readdata;
	logic [dma_pkg::num_chan-1:0][dma_pkg::page_w-1:0] page;
	dma_pkg::chan_mem_t [dma_pkg::num_chan-1:0]        chan_mem;
	logic [dma_pkg::data_w-1:0]                        regs_readdata;
	logic [dma_pkg::data_w-1:0]                        page_readdata;
	logic                                              flip_flop;
	logic                                              master_clear;
	logic                                              disabled;
	logic                                              rd_page;   // last read went to the page ports

	dma_regs regs_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.io           (io),
		.dreq         (dreq),
		.tc           (chan_tc),
		.auto_init    (auto_init),
		.chan_readdata(chan_readdata),
		.readdata     (regs_readdata),
		.flip_flop    (flip_flop),
		.master_clear (master_clear),
		.req          (req),
		.disabled     (disabled)
	);

	dma_page page_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.io      (io),
		.page    (page),
		.readdata(page_readdata)
	);

	for (genvar i = 0; i < dma_pkg::num_chan; i++) begin : g_chan
		dma_chan #(
			.chan_num(i)
		) chan_i (
			.clk          (clk),
			.rst_n        (rst_n),
			.master_clear (master_clear),
			.io           (io),
			.flip_flop    (flip_flop),
			.readdata     (chan_readdata[i]),
			.grant        (grant[i]),
			.dev_writedata(dev_writedata[i]),
			.ack          (dack[i]),
			.ack_data     (dev_readdata[i]),
			.chan_mem     (chan_mem[i]),
			.mem_rsp      (mem_rsp),
			.busy         (busy[i]),
			.tc           (chan_tc[i]),
			.auto_init    (auto_init[i])
		);
	end

	dma_arbiter arb_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (req),
		.disabled(disabled),
		.busy    (busy),
		.page    (page),
		.chan_mem(chan_mem),
		.grant   (grant),
		.mem_req (mem_req)
	);

	// --------------------
	// device tc, one cycle after the last update
	always_ff @(posedge clk) begin
		if (!rst_n)
			tc <= '0;
		else
			tc <= chan_tc;
	end

	// readback source follows the strobe, data comes a cycle later
	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_page <= 1'b0;
		else if (io.read)
			rd_page <= io.page_cs;
	end

	assign io_readdata = rd_page ? page_readdata : regs_readdata;

endmodule

//--- tests/dma_tb_tasks.svh
// dma testbench helper tasks

// xorshift32 step for the memory stall pattern
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// unwritten memory, every address bit counts
function automatic logic [7:0] fill_byte(input logic [23:0] a);
	return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'hA5;
endfunction

function automatic logic [3:0] page_port(input int ch);
	case (ch)
		0: return 4'h7;
		1: return 4'h3;
		2: return 4'h1;
		default: return 4'h2;
	endcase
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		$display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		fail_run();
	end
endtask

// --------------------
// cpu port access
task automatic io_write(input logic pg, input logic [3:0] a, input logic [7:0] d);
	@(posedge clk);
	io <= dma_pkg::io_req_t'({a, 1'b0, 1'b1, d, !pg, pg});
	@(posedge clk);
	io <= '0;
endtask

task automatic io_read(input logic pg, input logic [3:0] a, output logic [7:0] d);
	@(posedge clk);
	io <= dma_pkg::io_req_t'({a, 1'b1, 1'b0, 8'h00, !pg, pg});
	@(posedge clk);
	io <= '0;
	@(negedge clk);
	d = io_readdata; // registered, stable by now
endtask

task automatic read_expect(input logic pg, input logic [3:0] a, input logic [7:0] exp,
	input string name);
	logic [7:0] d;
	io_read(pg, a, d);
	check_eq(name, d, exp);
endtask

task automatic prog_chan(input int ch, input logic [15:0] base, input logic [15:0] cnt,
	input logic [7:0] mode, input logic [7:0] pg);
	io_write(0, dma_pkg::reg_clear_ff, 8'h00);
	io_write(0, 4'(2 * ch), base[7:0]);
	io_write(0, 4'(2 * ch), base[15:8]);
	io_write(0, 4'(2 * ch + 1), cnt[7:0]);
	io_write(0, 4'(2 * ch + 1), cnt[15:8]);
	io_write(0, dma_pkg::reg_mode, mode | 8'(ch));
	io_write(1, page_port(ch), pg);
endtask

task automatic check_access(input int idx, input logic [23:0] a, input logic wr,
	input logic [7:0] d);
	check_eq("mem_req.address", acc_q[idx].addr, a);
	check_eq("mem_req.write", acc_q[idx].wr, wr);
	check_eq("mem data", acc_q[idx].data, d);
endtask

//--- tests/dma_tb.sv
// dma engine testbench
`timescale 1ns/1ps

module dma_tb;

	localparam int clk_period     = 40;
	localparam int total_bytes    = 32;
	localparam int timeout_cycles = total_bytes * 40 + 2000;

	typedef struct packed {
		logic [23:0] addr;
		logic        wr;
		logic [7:0]  data;
	} acc_t;

	logic                  clk = 1'b0;
	logic                  rst_n;
	dma_pkg::io_req_t      io;
	logic [7:0]            io_readdata;
	dma_pkg::mem_req_t     mem_req;
	dma_pkg::mem_rsp_t     mem_rsp;
	logic [3:0]            dreq;
	logic [3:0]            dack;
	logic [3:0]            tc;
	logic [3:0][7:0]       dev_writedata;
	logic [3:0][7:0]       dev_readdata;
	logic [7:0]            mem_data [logic [23:0]];
	logic [31:0]           rng = 32'd61;
	acc_t                  acc_q [$];
	logic [7:0]            dev_q [$];
	int                    dack_cnt [4];
	int                    tc_cnt [4];

	always #(clk_period / 2) clk = ~clk;

	dma_top dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.io           (io),
		.io_readdata  (io_readdata),
		.mem_req      (mem_req),
		.mem_rsp      (mem_rsp),
		.dreq         (dreq),
		.dack         (dack),
		.tc           (tc),
		.dev_writedata(dev_writedata),
		.dev_readdata (dev_readdata)
	);

	task automatic fail_run;
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	`include "dma_tb_tasks.svh"

	// --------------------
	// memory model with random stalls
	always @(posedge clk) begin
		mem_rsp.readdatavalid <= 1'b0;
		if (rst_n && (mem_req.read || mem_req.write) && !mem_rsp.waitrequest) begin
			if (mem_req.write) begin
				mem_data[mem_req.address] = mem_req.writedata;
				acc_q.push_back({mem_req.address, 1'b1, mem_req.writedata});
			end else begin
				mem_rsp.readdatavalid <= 1'b1;
				mem_rsp.readdata <= mem_data.exists(mem_req.address) ?
					mem_data[mem_req.address] : fill_byte(mem_req.address);
				acc_q.push_back({mem_req.address, 1'b0, mem_data.exists(mem_req.address) ?
					mem_data[mem_req.address] : fill_byte(mem_req.address)});
			end
		end
		rng = xorshift(rng);
		mem_rsp.waitrequest <= rng[1:0] == 2'b00;
	end

	// device side gives a new byte after each dack
	always @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (rst_n && dack[i]) begin
				dack_cnt[i]++;
				dev_q.push_back(dev_readdata[i]);
				dev_writedata[i] <= dev_writedata[i] + 8'h11;
			end
			if (rst_n && tc[i])
				tc_cnt[i]++;
		end
	end

	task automatic wait_tc(input int ch, input int target);
		while (tc_cnt[ch] < target)
			@(posedge clk);
		repeat (10) @(posedge clk);
	endtask

	initial begin
		#(timeout_cycles * clk_period);
		$display("watchdog expired before the test sequence finished");
		fail_run();
	end

	// --------------------
	// test sequence
	initial begin
		logic [7:0] w0;
		rst_n = 1'b0;
		io = '0;
		mem_rsp = '0;
		dreq = '0;
		dev_writedata = {8'hC0, 8'h80, 8'h40, 8'h10};
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// everything masked after reset
		read_expect(0, dma_pkg::reg_mask_all, 8'h0F, "mask");
		read_expect(0, dma_pkg::reg_status_cmd, 8'h00, "status");
		@(posedge clk);
		dreq <= 4'hF;
		repeat (20) begin
			@(negedge clk);
			check_eq("mem_req.read", mem_req.read, 1'b0);
			check_eq("mem_req.write", mem_req.write, 1'b0);
			check_eq("dack", dack, 4'h0);
			check_eq("tc", tc, 4'h0);
		end
		@(posedge clk);
		dreq <= 4'h0;

		// register readback through the flip-flop
		prog_chan(0, 16'h1234, 16'hABCD, 8'h04, 8'h10);
		io_write(0, dma_pkg::reg_clear_ff, 8'h00);
		io_write(0, 4'h0, 8'h55);
		io_write(0, dma_pkg::reg_clear_ff, 8'h00);
		io_write(0, 4'h0, 8'h66); // low byte again
		io_write(0, dma_pkg::reg_clear_ff, 8'h00);
		read_expect(0, 4'h0, 8'h66, "addr low");
		read_expect(0, 4'h0, 8'h12, "addr high");
		read_expect(0, 4'h1, 8'hCD, "count low");
		read_expect(0, 4'h1, 8'hAB, "count high");
		for (int i = 0; i < 4; i++)
			io_write(1, page_port(i), 8'h10 + 8'(i));
		for (int i = 0; i < 4; i++)
			read_expect(1, page_port(i), 8'h10 + 8'(i), "page");
		read_expect(1, 4'h0, 8'h00, "unmapped page");

		// six-byte write transfer on channel 1
		prog_chan(1, 16'h0100, 16'd5, 8'h04, 8'h21);
		acc_q.delete();
		w0 = dev_writedata[1];
		io_write(0, dma_pkg::reg_mask_single, 8'h01);
		dreq[1] <= 1'b1;
		wait_tc(1, 1);
		dreq[1] <= 1'b0;
		check_eq("access count", acc_q.size(), 6);
		for (int i = 0; i < 6; i++)
			check_access(i, 24'h210100 + 24'(i), 1'b1, w0 + 8'(17 * i));
		check_eq("dack count", dack_cnt[1], 6);
		check_eq("tc count", tc_cnt[1], 1);
		read_expect(0, dma_pkg::reg_status_cmd, 8'h02, "status");
		read_expect(0, dma_pkg::reg_status_cmd, 8'h00, "status after read");
		read_expect(0, dma_pkg::reg_mask_all, 8'h0F, "mask");

		// decrementing read transfer on channel 2
		prog_chan(2, 16'h0050, 16'd4, 8'h28, 8'h33);
		acc_q.delete();
		dev_q.delete();
		io_write(0, dma_pkg::reg_mask_single, 8'h02);
		dreq[2] <= 1'b1;
		wait_tc(2, 1);
		dreq[2] <= 1'b0;
		check_eq("access count", acc_q.size(), 5);
		for (int i = 0; i < 5; i++) begin
			check_access(i, 24'h330050 - 24'(i), 1'b0, fill_byte(24'h330050 - 24'(i)));
			check_eq("dev_readdata", dev_q[i], fill_byte(24'h330050 - 24'(i)));
		end
		read_expect(0, dma_pkg::reg_status_cmd, 8'h04, "status");

		// auto-init on channel 3 over two blocks of three
		prog_chan(3, 16'h0200, 16'd2, 8'h14, 8'h44);
		acc_q.delete();
		w0 = dev_writedata[3];
		io_write(0, dma_pkg::reg_mask_single, 8'h03);
		dreq[3] <= 1'b1;
		wait_tc(3, 2);
		dreq[3] <= 1'b0;
		repeat (40) @(posedge clk); // let a trailing byte finish
		for (int i = 0; i < 6; i++)
			check_access(i, 24'h440200 + 24'(i % 3), 1'b1, w0 + 8'(17 * i));
		read_expect(0, dma_pkg::reg_mask_all, 8'h07, "mask after auto-init");
		read_expect(0, dma_pkg::reg_status_cmd, 8'h08, "status");
		io_write(0, dma_pkg::reg_mask_single, 8'h07);

		// channel 0 goes before channel 2
		prog_chan(0, 16'h0300, 16'd3, 8'h04, 8'h12);
		prog_chan(2, 16'h0400, 16'd3, 8'h08, 8'h34);
		acc_q.delete();
		w0 = dev_writedata[0];
		io_write(0, dma_pkg::reg_mask_single, 8'h00);
		io_write(0, dma_pkg::reg_mask_single, 8'h02);
		dreq <= 4'b0101;
		wait_tc(0, 1);
		wait_tc(2, 2);
		dreq <= 4'h0;
		check_eq("access count", acc_q.size(), 8);
		for (int i = 0; i < 4; i++) begin
			check_access(i, 24'h120300 + 24'(i), 1'b1, w0 + 8'(17 * i));
			check_access(i + 4, 24'h340400 + 24'(i), 1'b0, fill_byte(24'h340400 + 24'(i)));
		end

		// masked channel and then the disable bit
		acc_q.delete();
		io_write(0, dma_pkg::reg_mask_all, 8'h0F);
		dreq[1] <= 1'b1;
		repeat (30) @(posedge clk);
		io_write(0, dma_pkg::reg_status_cmd, 8'h04);
		io_write(0, dma_pkg::reg_clear_mask, 8'h00);
		repeat (30) @(posedge clk);
		dreq[1] <= 1'b0;
		repeat (4) @(posedge clk);
		io_write(0, dma_pkg::reg_status_cmd, 8'h00);
		repeat (10) @(posedge clk);
		check_eq("gated access count", acc_q.size(), 0);

		// software request without dreq
		prog_chan(1, 16'h0500, 16'd1, 8'h04, 8'h21);
		w0 = dev_writedata[1];
		io_write(0, dma_pkg::reg_request, 8'h05);
		wait_tc(1, 2);
		check_eq("access count", acc_q.size(), 2);
		for (int i = 0; i < 2; i++)
			check_access(i, 24'h210500 + 24'(i), 1'b1, w0 + 8'(17 * i));

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- build.f
+incdir+tests
design/dma_pkg.sv
design/dma_chan.sv
design/dma_regs.sv
design/dma_page.sv
design/dma_arbiter.sv
design/dma_top.sv
tests/dma_tb.sv

//--- Bender.yml
package:
  name: dma_engine

sources:
  - design/dma_pkg.sv
  - design/dma_chan.sv
  - design/dma_regs.sv
  - design/dma_page.sv
  - design/dma_arbiter.sv
  - design/dma_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/dma_tb.sv
